// ==== rtl/qtable_config.svh ====
`ifndef QTABLE_CONFIG_SVH
`define QTABLE_CONFIG_SVH

// one width for every field
// ids, hop counts, energy and q-values alike
`define QT_WORD_WIDTH     16

// table depths
`define QT_NBR_DEPTH      16
`define QT_CH_DEPTH       8

// index widths, log2 of the depths
`define QT_NBR_IDX_WIDTH  4
`define QT_CH_IDX_WIDTH   3

// counts need one more bit to reach the full depth
`define QT_NBR_CNT_WIDTH  5
`define QT_CH_CNT_WIDTH   4

`endif

// ==== rtl/qTableTypesPkg.sv ====
`include "qtable_config.svh"

package qTableTypesPkg;

    // one table field word
    typedef logic [`QT_WORD_WIDTH-1:0]    qWord_t;

    // neighbor table addressing
    typedef logic [`QT_NBR_IDX_WIDTH-1:0] nbrIdx_t;  // entry select
    typedef logic [`QT_NBR_CNT_WIDTH-1:0] nbrCnt_t;  // 0 .. depth

    // known cluster-head list addressing
    typedef logic [`QT_CH_IDX_WIDTH-1:0]  chIdx_t;
    typedef logic [`QT_CH_CNT_WIDTH-1:0]  chCnt_t;

endpackage

// ==== rtl/qUpdateCtrlPkg.sv ====
`include "qtable_config.svh"

package qUpdateCtrlPkg;

    // update sequence of the controller
    // one packet walks IDLE -> neighbor scan -> ch scan -> DONE
    typedef enum logic [2:0] {
        IDLE       = 3'd0,  // waiting for en
        CHECK_NBR  = 3'd1,  // compare neighbor entry n
        ADD_NBR    = 3'd2,  // append full entry
        UPDATE_NBR = 3'd3,  // overwrite cluster id, energy, q
        CHECK_CH   = 3'd4,  // compare ch entry k
        ADD_CH     = 3'd5,  // append advertised head
        DONE       = 3'd6   // one cycle done pulse
    } updState_t;

endpackage

// ==== rtl/neighborTable.sv ====
`timescale 1ns/100ps
`include "qtable_config.svh"

module neighborTable (
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    nbrAdd,        // append at nbrCount
    input  logic                    nbrUpdate,     // in-place update at nbrWrIdx
    input  qTableTypesPkg::nbrIdx_t nbrWrIdx,
    input  qTableTypesPkg::qWord_t  pktNodeID,
    input  qTableTypesPkg::qWord_t  pktHops,
    input  qTableTypesPkg::qWord_t  pktClusterID,
    input  qTableTypesPkg::qWord_t  pktEnergy,
    input  qTableTypesPkg::qWord_t  pktQValue,
    input  qTableTypesPkg::nbrIdx_t nbrScanIdx,    // controller compare port
    input  qTableTypesPkg::nbrIdx_t nbrRdIdx,      // outside read port
    output qTableTypesPkg::qWord_t  scanNodeID,
    output qTableTypesPkg::qWord_t  rdNodeID,
    output qTableTypesPkg::qWord_t  rdHops,
    output qTableTypesPkg::qWord_t  rdClusterID,
    output qTableTypesPkg::qWord_t  rdEnergy,
    output qTableTypesPkg::qWord_t  rdQValue,
    output qTableTypesPkg::nbrCnt_t nbrCount
);

    // five parallel field banks sharing one row per neighbor
    qTableTypesPkg::qWord_t  nodeIdMem    [`QT_NBR_DEPTH];
    qTableTypesPkg::qWord_t  hopsMem      [`QT_NBR_DEPTH];
    qTableTypesPkg::qWord_t  clusterIdMem [`QT_NBR_DEPTH];
    qTableTypesPkg::qWord_t  energyMem    [`QT_NBR_DEPTH];
    qTableTypesPkg::qWord_t  qValueMem    [`QT_NBR_DEPTH];

    qTableTypesPkg::nbrIdx_t appendIdx;   // next free row
    qTableTypesPkg::nbrIdx_t wrIdx;       // row hit by either write

    // controller stops appends when full so the count stays within depth
    assign appendIdx = nbrCount[`QT_NBR_IDX_WIDTH-1:0];
    assign wrIdx     = nbrAdd ? appendIdx : nbrWrIdx;

    // id and hops only on append
    // stored hops survive an update
    always_ff @(posedge clk) begin
        if (nbrAdd) begin
            nodeIdMem[appendIdx] <= pktNodeID;
            hopsMem[appendIdx]   <= pktHops;
        end
    end

    // fields common to append and update
    always_ff @(posedge clk) begin
        if (nbrAdd || nbrUpdate) begin
            clusterIdMem[wrIdx] <= pktClusterID;
            energyMem[wrIdx]    <= pktEnergy;
            qValueMem[wrIdx]    <= pktQValue;
        end
    end

    // entry counter
    always_ff @(posedge clk) begin
        if (!nrst) begin
            nbrCount <= '0;
        end else if (nbrAdd) begin
            nbrCount <= nbrCount + 1'b1;
        end
    end

    // async scan port for the id compare
    assign scanNodeID = nodeIdMem[nbrScanIdx];

    // async read port for the routing side
    assign rdNodeID    = nodeIdMem[nbrRdIdx];
    assign rdHops      = hopsMem[nbrRdIdx];
    assign rdClusterID = clusterIdMem[nbrRdIdx];
    assign rdEnergy    = energyMem[nbrRdIdx];
    assign rdQValue    = qValueMem[nbrRdIdx];

endmodule

// ==== rtl/knownChTable.sv ====
`timescale 1ns/100ps
`include "qtable_config.svh"

module knownChTable (
    input  logic                   clk,
    input  logic                   nrst,
    input  logic                   chAdd,        // append strobe
    input  qTableTypesPkg::qWord_t pktKnownCH,   // latched advertised head
    input  qTableTypesPkg::chIdx_t chScanIdx,
    input  qTableTypesPkg::chIdx_t chRdIdx,
    output qTableTypesPkg::qWord_t scanKnownCH,
    output qTableTypesPkg::qWord_t rdKnownCH,
    output qTableTypesPkg::chCnt_t chCount
);

    // list of cluster heads heard so far
    qTableTypesPkg::qWord_t chMem [`QT_CH_DEPTH];

    qTableTypesPkg::chIdx_t appendIdx;

    assign appendIdx = chCount[`QT_CH_IDX_WIDTH-1:0];  // full case filtered upstream

    always_ff @(posedge clk) begin
        if (chAdd) begin
            chMem[appendIdx] <= pktKnownCH;
        end
    end

    // number of valid heads
    always_ff @(posedge clk) begin
        if (!nrst) begin
            chCount <= '0;
        end else if (chAdd) begin
            chCount <= chCount + 1'b1;
        end
    end

    assign scanKnownCH = chMem[chScanIdx];  // compare port
    assign rdKnownCH   = chMem[chRdIdx];    // outside read

endmodule

// ==== rtl/updateControl.sv ====
`timescale 1ns/100ps
`include "qtable_config.svh"

module updateControl (
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    en,            // sampled in IDLE only
    input  qTableTypesPkg::qWord_t  fSourceID,
    input  qTableTypesPkg::qWord_t  fSourceHops,
    input  qTableTypesPkg::qWord_t  fClusterID,
    input  qTableTypesPkg::qWord_t  fEnergyLeft,
    input  qTableTypesPkg::qWord_t  fQValue,
    input  qTableTypesPkg::qWord_t  fKnownCH,      // head advertised by the sender
    input  qTableTypesPkg::qWord_t  scanNodeID,    // neighbor id at nbrScanIdx
    input  qTableTypesPkg::qWord_t  scanKnownCH,   // head at chScanIdx
    input  qTableTypesPkg::nbrCnt_t nbrCount,
    input  qTableTypesPkg::chCnt_t  chCount,
    output logic                    busy,
    output logic                    done,
    output qTableTypesPkg::nbrIdx_t nbrScanIdx,
    output qTableTypesPkg::nbrIdx_t nbrWrIdx,
    output qTableTypesPkg::chIdx_t  chScanIdx,
    output logic                    nbrAdd,
    output logic                    nbrUpdate,
    output logic                    chAdd,
    output qTableTypesPkg::qWord_t  pktNodeID,
    output qTableTypesPkg::qWord_t  pktHops,
    output qTableTypesPkg::qWord_t  pktClusterID,
    output qTableTypesPkg::qWord_t  pktEnergy,
    output qTableTypesPkg::qWord_t  pktQValue,
    output qTableTypesPkg::qWord_t  pktKnownCH
);

    localparam qTableTypesPkg::nbrCnt_t NbrDepth = `QT_NBR_DEPTH;
    localparam qTableTypesPkg::chCnt_t  ChDepth  = `QT_CH_DEPTH;

    qUpdateCtrlPkg::updState_t state;
    qUpdateCtrlPkg::updState_t nextState;

    qTableTypesPkg::nbrCnt_t   n;   // neighbor scan position
    qTableTypesPkg::chCnt_t    k;   // ch scan position

    logic nbrScanEnd;   // every stored neighbor compared
    logic nbrHit;
    logic chScanEnd;
    logic chHit;

    logic pktLoad;

    assign pktLoad = (state == qUpdateCtrlPkg::IDLE) && en;

    // scan positions run one past the last entry, index drops the top bit
    assign nbrScanIdx = n[`QT_NBR_IDX_WIDTH-1:0];
    assign chScanIdx  = k[`QT_CH_IDX_WIDTH-1:0];

    assign nbrScanEnd = (n == nbrCount);
    assign nbrHit     = !nbrScanEnd && (scanNodeID == pktNodeID);  // stale row ignored
    assign chScanEnd  = (k == chCount);
    assign chHit      = !chScanEnd && (scanKnownCH == pktKnownCH);

    // packet latch
    always_ff @(posedge clk) begin
        if (pktLoad) begin
            pktNodeID    <= fSourceID;
            pktHops      <= fSourceHops;
            pktClusterID <= fClusterID;
            pktEnergy    <= fEnergyLeft;
            pktQValue    <= fQValue;
            pktKnownCH   <= fKnownCH;
        end
    end

    // next-state decode
    always_comb begin
        nextState = state;
        case (state)
            qUpdateCtrlPkg::IDLE: begin
                if (en) begin
                    nextState = qUpdateCtrlPkg::CHECK_NBR;
                end
            end
            qUpdateCtrlPkg::CHECK_NBR: begin
                if (nbrHit) begin
                    nextState = qUpdateCtrlPkg::UPDATE_NBR;
                end else if (nbrScanEnd) begin
                    // full table drops the neighbor data, ch still checked
                    nextState = (nbrCount < NbrDepth) ? qUpdateCtrlPkg::ADD_NBR
                                                      : qUpdateCtrlPkg::CHECK_CH;
                end
            end
            qUpdateCtrlPkg::ADD_NBR,
            qUpdateCtrlPkg::UPDATE_NBR: begin
                nextState = qUpdateCtrlPkg::CHECK_CH;  // write lands on this edge
            end
            qUpdateCtrlPkg::CHECK_CH: begin
                if (chHit) begin
                    nextState = qUpdateCtrlPkg::DONE;  // head already known
                end else if (chScanEnd) begin
                    nextState = (chCount < ChDepth) ? qUpdateCtrlPkg::ADD_CH
                                                    : qUpdateCtrlPkg::DONE;
                end
            end
            qUpdateCtrlPkg::ADD_CH: begin
                nextState = qUpdateCtrlPkg::DONE;
            end
            qUpdateCtrlPkg::DONE: begin
                nextState = qUpdateCtrlPkg::IDLE;
            end
            default: begin
                nextState = qUpdateCtrlPkg::IDLE;
            end
        endcase
    end

    // state and scan counters
    always_ff @(posedge clk) begin
        if (!nrst) begin
            state <= qUpdateCtrlPkg::IDLE;
            n     <= '0;
            k     <= '0;
        end else begin
            state <= nextState;
            // n steps only on a miss, parks on the match otherwise
            if (state != qUpdateCtrlPkg::CHECK_NBR) begin
                n <= '0;
            end else if (!nbrHit && !nbrScanEnd) begin
                n <= n + 1'b1;
            end
            if (state != qUpdateCtrlPkg::CHECK_CH) begin
                k <= '0;
            end else if (!chHit && !chScanEnd) begin
                k <= k + 1'b1;
            end
        end
    end

    // row of the last compare, valid in UPDATE_NBR
    always_ff @(posedge clk) begin
        if (state == qUpdateCtrlPkg::CHECK_NBR) begin
            nbrWrIdx <= nbrScanIdx;
        end
    end

    // outputs straight from state
    assign busy      = (state != qUpdateCtrlPkg::IDLE);
    assign done      = (state == qUpdateCtrlPkg::DONE);      // busy still high here
    assign nbrAdd    = (state == qUpdateCtrlPkg::ADD_NBR);
    assign nbrUpdate = (state == qUpdateCtrlPkg::UPDATE_NBR);
    assign chAdd     = (state == qUpdateCtrlPkg::ADD_CH);

endmodule

// ==== rtl/qTableUpdate.sv ====
`timescale 1ns/100ps

module qTableUpdate (
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    en,
    input  qTableTypesPkg::qWord_t  fSourceID,
    input  qTableTypesPkg::qWord_t  fSourceHops,
    input  qTableTypesPkg::qWord_t  fClusterID,
    input  qTableTypesPkg::qWord_t  fEnergyLeft,
    input  qTableTypesPkg::qWord_t  fQValue,
    input  qTableTypesPkg::qWord_t  fKnownCH,
    input  qTableTypesPkg::nbrIdx_t nbrRdIdx,
    input  qTableTypesPkg::chIdx_t  chRdIdx,
    output logic                    busy,
    output logic                    done,
    output qTableTypesPkg::nbrCnt_t nbrCount,
    output qTableTypesPkg::chCnt_t  chCount,
    output qTableTypesPkg::qWord_t  rdNodeID,
    output qTableTypesPkg::qWord_t  rdHops,
    output qTableTypesPkg::qWord_t  rdClusterID,
    output qTableTypesPkg::qWord_t  rdEnergy,
    output qTableTypesPkg::qWord_t  rdQValue,
    output qTableTypesPkg::qWord_t  rdKnownCH
);

    // controller <-> tables
    qTableTypesPkg::qWord_t  scanNodeID;
    qTableTypesPkg::qWord_t  scanKnownCH;
    qTableTypesPkg::nbrIdx_t nbrScanIdx;
    qTableTypesPkg::nbrIdx_t nbrWrIdx;
    qTableTypesPkg::chIdx_t  chScanIdx;
    logic                    nbrAdd;
    logic                    nbrUpdate;
    logic                    chAdd;

    // latched packet, write data for both tables
    qTableTypesPkg::qWord_t  pktNodeID;
    qTableTypesPkg::qWord_t  pktHops;
    qTableTypesPkg::qWord_t  pktClusterID;
    qTableTypesPkg::qWord_t  pktEnergy;
    qTableTypesPkg::qWord_t  pktQValue;
    qTableTypesPkg::qWord_t  pktKnownCH;

    updateControl ctrl_i (
        .clk          (clk),
        .nrst         (nrst),
        .en           (en),
        .fSourceID    (fSourceID),
        .fSourceHops  (fSourceHops),
        .fClusterID   (fClusterID),
        .fEnergyLeft  (fEnergyLeft),
        .fQValue      (fQValue),
        .fKnownCH     (fKnownCH),
        .scanNodeID   (scanNodeID),
        .scanKnownCH  (scanKnownCH),
        .nbrCount     (nbrCount),
        .chCount      (chCount),
        .busy         (busy),
        .done         (done),
        .nbrScanIdx   (nbrScanIdx),
        .nbrWrIdx     (nbrWrIdx),
        .chScanIdx    (chScanIdx),
        .nbrAdd       (nbrAdd),
        .nbrUpdate    (nbrUpdate),
        .chAdd        (chAdd),
        .pktNodeID    (pktNodeID),
        .pktHops      (pktHops),
        .pktClusterID (pktClusterID),
        .pktEnergy    (pktEnergy),
        .pktQValue    (pktQValue),
        .pktKnownCH   (pktKnownCH)
    );

    neighborTable nbrTable_i (
        .clk          (clk),
        .nrst         (nrst),
        .nbrAdd       (nbrAdd),
        .nbrUpdate    (nbrUpdate),
        .nbrWrIdx     (nbrWrIdx),
        .pktNodeID    (pktNodeID),
        .pktHops      (pktHops),
        .pktClusterID (pktClusterID),
        .pktEnergy    (pktEnergy),
        .pktQValue    (pktQValue),
        .nbrScanIdx   (nbrScanIdx),
        .nbrRdIdx     (nbrRdIdx),
        .scanNodeID   (scanNodeID),
        .rdNodeID     (rdNodeID),
        .rdHops       (rdHops),
        .rdClusterID  (rdClusterID),
        .rdEnergy     (rdEnergy),
        .rdQValue     (rdQValue),
        .nbrCount     (nbrCount)
    );

    knownChTable chTable_i (
        .clk          (clk),
        .nrst         (nrst),
        .chAdd        (chAdd),
        .pktKnownCH   (pktKnownCH),
        .chScanIdx    (chScanIdx),
        .chRdIdx      (chRdIdx),
        .scanKnownCH  (scanKnownCH),
        .rdKnownCH    (rdKnownCH),
        .chCount      (chCount)
    );

endmodule

// ==== verif/qTableUpdate_props.sv ====
`timescale 1ns/100ps
`include "qtable_config.svh"

module qTableUpdate_props (
    input logic                      clk,
    input logic                      nrst,
    input qUpdateCtrlPkg::updState_t state,
    input logic                      done,
    input logic                      nbrAdd,
    input logic                      nbrUpdate,
    input logic                      chAdd,
    input qTableTypesPkg::nbrCnt_t   nbrCount
);

    int propFails = 0;  // read by the testbench at the end

    // done is a single-cycle pulse
    donePulse: assert property (@(posedge clk) disable iff (!nrst) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            propFails++;
        end

    // strobes only come from the write states
    noWriteInIdle: assert property (@(posedge clk) disable iff (!nrst)
        (state == qUpdateCtrlPkg::IDLE) |-> !(nbrAdd || nbrUpdate || chAdd))
        else begin
            $error("write strobe raised while the controller was idle");
            propFails++;
        end

    addUpdateExclusive: assert property (@(posedge clk) disable iff (!nrst)
        !(nbrAdd && nbrUpdate))
        else begin
            $error("neighbor append and update strobes high together");
            propFails++;
        end

    nbrCountBound: assert property (@(posedge clk) disable iff (!nrst)
        nbrCount <= `QT_NBR_DEPTH)
        else begin
            $error("neighbor count ran past the table depth");
            propFails++;
        end

endmodule

bind updateControl qTableUpdate_props props_i (
    .clk       (clk),
    .nrst      (nrst),
    .state     (state),
    .done      (done),
    .nbrAdd    (nbrAdd),
    .nbrUpdate (nbrUpdate),
    .chAdd     (chAdd),
    .nbrCount  (nbrCount)
);

// ==== verif/qTableUpdate_tb.sv ====
`timescale 1ns/100ps
`include "qtable_config.svh"

module qTableUpdate_tb;

    localparam int TotalPkts  = 1 + 1 + 1 + 20 + 24;  // packets over all tests
    localparam int CycleLimit = 200 * TotalPkts;

    logic clk;
    logic nrst;
    logic en;
    qTableTypesPkg::qWord_t  fSourceID, fSourceHops, fClusterID;
    qTableTypesPkg::qWord_t  fEnergyLeft, fQValue, fKnownCH;
    qTableTypesPkg::nbrIdx_t nbrRdIdx;
    qTableTypesPkg::chIdx_t  chRdIdx;
    logic busy;
    logic done;
    qTableTypesPkg::nbrCnt_t nbrCount;
    qTableTypesPkg::chCnt_t  chCount;
    qTableTypesPkg::qWord_t  rdNodeID, rdHops, rdClusterID, rdEnergy, rdQValue, rdKnownCH;

    // reference model of both tables
    qTableTypesPkg::qWord_t mNodeId [`QT_NBR_DEPTH];
    qTableTypesPkg::qWord_t mHops   [`QT_NBR_DEPTH];
    qTableTypesPkg::qWord_t mCluster[`QT_NBR_DEPTH];
    qTableTypesPkg::qWord_t mEnergy [`QT_NBR_DEPTH];
    qTableTypesPkg::qWord_t mQValue [`QT_NBR_DEPTH];
    qTableTypesPkg::qWord_t mKnownCh[`QT_CH_DEPTH];
    int mNbrCnt;
    int mChCnt;

    int errors = 0;
    int doneCount = 0;   // done cycles seen since time 0
    int cycleCount;

    qTableUpdate dut_i (.*);

    always #20 clk = ~clk;

    // done sampled mid-cycle away from the edge
    always @(negedge clk) begin
        if (nrst && done) doneCount++;
    end

    task automatic compareWord(input string name, input qTableTypesPkg::qWord_t actual,
                               input qTableTypesPkg::qWord_t expected);
        if (actual !== expected) begin
            errors++;
            $display("Error: %s is %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic compareCount(input string name, input qTableTypesPkg::nbrCnt_t actual,
                                input qTableTypesPkg::nbrCnt_t expected);
        if (actual !== expected) begin
            errors++;
            $display("Error: %s is %h, expected %h", name, actual, expected);
        end
    endtask

    // a hit keeps hops and a miss appends while room is left
    task automatic modelPacket(input qTableTypesPkg::qWord_t id, hops, cl, energy, q, ch);
        int hit;
        hit = -1;
        for (int i = 0; i < mNbrCnt; i++) begin
            if (mNodeId[i] == id) begin
                hit = i;
            end
        end
        if (hit >= 0) begin
            mCluster[hit] = cl;
            mEnergy[hit]  = energy;
            mQValue[hit]  = q;
        end else if (mNbrCnt < `QT_NBR_DEPTH) begin
            mNodeId[mNbrCnt]  = id;
            mHops[mNbrCnt]    = hops;
            mCluster[mNbrCnt] = cl;
            mEnergy[mNbrCnt]  = energy;
            mQValue[mNbrCnt]  = q;
            mNbrCnt++;
        end
        hit = -1;
        for (int i = 0; i < mChCnt; i++) begin
            if (mKnownCh[i] == ch) begin
                hit = i;
            end
        end
        if (hit < 0 && mChCnt < `QT_CH_DEPTH) begin
            mKnownCh[mChCnt] = ch;
            mChCnt++;
        end
    endtask

    task automatic applyReset();
        @(posedge clk);
        #2;
        nrst = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        nrst = 1'b1;
        mNbrCnt = 0;  // model tables empty again
        mChCnt  = 0;
    endtask

    // sends one packet and returns one cycle after the done pulse
    task automatic sendPacket(input qTableTypesPkg::qWord_t id, hops, cl, energy, q, ch);
        @(posedge clk);
        #2;
        if (busy) begin
            errors++;
            $display("busy still high when the next packet was due");
        end
        fSourceID   = id;
        fSourceHops = hops;
        fClusterID  = cl;
        fEnergyLeft = energy;
        fQValue     = q;
        fKnownCH    = ch;
        en          = 1'b1;
        @(posedge clk);
        #2;
        en = 1'b0;
        if (!busy) begin
            errors++;
            $display("busy did not rise after the packet was taken");
        end
        do @(negedge clk); while (!done);  // watchdog bounds this wait
        @(negedge clk);
        if (done || busy) begin
            errors++;
            $display("done or busy still high one cycle after the done pulse");
        end
        modelPacket(id, hops, cl, energy, q, ch);
    endtask

    // walk every valid entry through the read ports
    task automatic checkTables();
        compareCount("nbrCount", nbrCount, qTableTypesPkg::nbrCnt_t'(mNbrCnt));
        compareCount("chCount", qTableTypesPkg::nbrCnt_t'(chCount),
                     qTableTypesPkg::nbrCnt_t'(mChCnt));
        for (int i = 0; i < mNbrCnt; i++) begin
            @(posedge clk);
            #2;
            nbrRdIdx = qTableTypesPkg::nbrIdx_t'(i);
            @(negedge clk);  // async read settled
            compareWord($sformatf("rdNodeID[%0d]", i), rdNodeID, mNodeId[i]);
            compareWord($sformatf("rdHops[%0d]", i), rdHops, mHops[i]);
            compareWord($sformatf("rdClusterID[%0d]", i), rdClusterID, mCluster[i]);
            compareWord($sformatf("rdEnergy[%0d]", i), rdEnergy, mEnergy[i]);
            compareWord($sformatf("rdQValue[%0d]", i), rdQValue, mQValue[i]);
        end
        for (int i = 0; i < mChCnt; i++) begin
            @(posedge clk);
            #2;
            chRdIdx = qTableTypesPkg::chIdx_t'(i);
            @(negedge clk);
            compareWord($sformatf("rdKnownCH[%0d]", i), rdKnownCH, mKnownCh[i]);
        end
    endtask

    task automatic testResetAndFirst();
        compareCount("nbrCount", nbrCount, '0);
        compareCount("chCount", qTableTypesPkg::nbrCnt_t'(chCount), '0);
        compareWord("busy", qTableTypesPkg::qWord_t'(busy), '0);
        compareWord("done", qTableTypesPkg::qWord_t'(done), '0);
        sendPacket(16'h0101, 16'h0003, 16'h0a00, 16'h7f00, 16'h1234, 16'h0a00);
        checkTables();
    endtask

    task automatic testUpdateInPlace();
        // same id with new hops that must not land
        sendPacket(16'h0101, 16'h0009, 16'h0b00, 16'h6e00, 16'h2345, 16'h0b00);
        checkTables();
    endtask

    task automatic testKnownHead();
        sendPacket(16'h0202, 16'h0002, 16'h0a00, 16'h5d00, 16'h3456, 16'h0a00);
        checkTables();
    endtask

    task automatic testFill();
        qTableTypesPkg::qWord_t ch;
        applyReset();
        for (int i = 0; i < 20; i++) begin
            // five repeating heads first and fresh heads once the table is full
            ch = (i < 16) ? 16'(16'h0c00 + (i % 5)) : 16'(16'h0c10 + i);
            sendPacket({i[7:0], 8'($urandom)}, 16'($urandom), 16'($urandom),
                       16'($urandom), 16'($urandom), ch);
        end
        compareCount("nbrCount", nbrCount, qTableTypesPkg::nbrCnt_t'(`QT_NBR_DEPTH));
        compareCount("chCount", qTableTypesPkg::nbrCnt_t'(chCount),
                     qTableTypesPkg::nbrCnt_t'(`QT_CH_DEPTH));
        checkTables();
    endtask

    task automatic testMixed();
        int doneBefore;
        applyReset();
        doneBefore = doneCount;
        for (int i = 0; i < 24; i++) begin
            // small id and head pools so repeats are common
            sendPacket(16'h0300 + 16'($urandom % 12), 16'($urandom % 8), 16'($urandom),
                       16'($urandom), 16'($urandom), 16'h0d00 + 16'($urandom % 6));
        end
        if (doneCount - doneBefore != 24) begin
            errors++;
            $display("done pulsed %0d times for 24 packets", doneCount - doneBefore);
        end
        checkTables();
    endtask

    // watchdog
    initial begin
        cycleCount = 0;
        while (cycleCount < CycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout after %0d cycles, a packet never finished", cycleCount);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int propFails;
        clk = 1'b0;
        nrst = 1'b0;
        en = 1'b0;
        fSourceID = '0;
        fSourceHops = '0;
        fClusterID = '0;
        fEnergyLeft = '0;
        fQValue = '0;
        fKnownCH = '0;
        nbrRdIdx = '0;
        chRdIdx = '0;
        void'($urandom(32'h8b5b));
        applyReset();
        testResetAndFirst();
        testUpdateInPlace();
        testKnownHead();
        testFill();
        testMixed();
        propFails = dut_i.ctrl_i.props_i.propFails;
        $display("%0d check errors, %0d assertion failures", errors, propFails);
        if (errors == 0 && propFails == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+rtl
rtl/qTableTypesPkg.sv
rtl/qUpdateCtrlPkg.sv
rtl/neighborTable.sv
rtl/knownChTable.sv
rtl/updateControl.sv
rtl/qTableUpdate.sv
verif/qTableUpdate_props.sv
verif/qTableUpdate_tb.sv
